// ==== compile.f ====
logic/lz77_clt_pkg.sv
logic/clt_phase_if.sv
logic/match_select_tree.sv
logic/phase_length_tracker.sv
logic/match_output_stage.sv
logic/lz77_cluster.sv
testbench/tb_lz77_cluster.sv

// ==== Bender.yml ====
package:
  name: lz77_cluster

sources:
  - files:
      - logic/lz77_clt_pkg.sv
      - logic/clt_phase_if.sv
      - logic/match_select_tree.sv
      - logic/phase_length_tracker.sv
      - logic/match_output_stage.sv
      - logic/lz77_cluster.sv
  - target: test
    files:
      - testbench/tb_lz77_cluster.sv

// ==== testbench/tb_lz77_cluster.sv ====
// Testbench for the LZ77 match cluster
// LFSR stimulus, cycle model of the cluster and per-cycle output checks

`timescale 1ns/10ps

module tb_lz77_cluster;
   import lz77_clt_pkg::*;

   localparam int TILES      = 4;
   localparam int LONGL      = 12;
   localparam int TILE_OFF_W = 3;
   localparam int OFF_W      = 5;
   localparam int MAX_CYCLES = 10000;
   localparam int M_IDLE     = 0;
   localparam int M_PLAIN    = 1;
   localparam int M_HOLD     = 2;
   localparam int M_LIMIT    = 3;
   localparam int M_MIXED    = 4;

   logic                                         clk;
   logic                                         clt_rst_n;
   logic                                         step_en;
   logic [TILES-1:0][PHASES-1:0][LONGL-1:0]      tile_fwd_therm;
   logic [TILES-1:0][PHASES-1:0][TILE_OFF_W-1:0] tile_offset;
   dmw_t                                         dmw_start;
   limit_op_e                                    limit_op;
   win_size_e                                    win_size;
   logic [PHASES-1:0][OFF_W-1:0]                 match_offset;
   logic [PHASES-1:0][LONGL-1:0]                 match_fwd_therm;
   logic [PHASES-1:0]                            match_truncated;
   logic                                         match_cont;

   logic [31:0] lfsr;
   int          mode;
   int          steps_seen;
   int          tile_len [TILES][PHASES];

   // Model state
   int                           m_limit;
   dmw_t                         m_dmw_r;
   dmw_t                         m_dmw_hold;
   int                           m_count [PHASES];
   logic [PHASES-1:0]            m_cont_r;
   logic [PHASES-1:0]            m_cont_2r;
   logic [PHASES-1:0]            m_valid;
   logic                         m_force_done_r;
   logic                         m_cont;
   logic [PHASES-1:0][OFF_W-1:0] m_off;
   logic [PHASES-1:0][LONGL-1:0] m_therm;
   logic [PHASES-1:0]            m_trunc;

   lz77_cluster i_dut (
      .clk             (clk),
      .clt_rst_n       (clt_rst_n),
      .step_en         (step_en),
      .tile_fwd_therm  (tile_fwd_therm),
      .tile_offset     (tile_offset),
      .dmw_start       (dmw_start),
      .limit_op        (limit_op),
      .win_size        (win_size),
      .match_offset    (match_offset),
      .match_fwd_therm (match_fwd_therm),
      .match_truncated (match_truncated),
      .match_cont      (match_cont)
   );

   always #2 clk = ~clk;

   // **************************************************************************
   // Random bits and error reporting
   // **************************************************************************
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r[i] = lfsr[0];
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   task automatic stop_run();
      $display("Regression failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_failure(input string what);
      $display("ERROR: %s", what);
      stop_run();
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_run();
   endtask

   // **************************************************************************
   // Reference model
   // **************************************************************************
   function automatic int decode_limit(input limit_op_e op, input win_size_e win);
      case (op)
         LIMIT_258: return 258;
         LIMIT_18:  return 18;
         LIMIT_64:  return 64;
         default: begin
            case (int'(win))
               0:       return 512;
               1:       return 4096;
               2:       return 8192;
               3:       return 16384;
               4:       return 32768;
               default: return 65535;
            endcase
         end
      endcase
   endfunction

   // Index 0 is phase 1 and the higher dmw bit of a phase wins
   function automatic int start_len(input int p, input dmw_t d);
      case (p)
         0:       return d[2] ? 21 : 0;
         1:       return d[3] ? 22 : 0;
         2:       return d[4] ? 23 : (d[0] ? 19 : 0);
         default: return d[5] ? 24 : (d[1] ? 20 : 0);
      endcase
   endfunction

   function automatic int mask_span(input int p);
      return (p == 3) ? 10 : ((p == 2) ? 9 : 8);
   endfunction

   function automatic logic [PHASES-1:0] fold(input dmw_t v);
      return v[5:2] | {v[1:0], 2'b00};
   endfunction

   task automatic reset_model();
      m_limit        = 0;
      m_dmw_r        = '0;
      m_dmw_hold     = '0;
      m_cont_r       = '0;
      m_cont_2r      = '0;
      m_valid        = '0;
      m_force_done_r = 1'b0;
      m_cont         = 1'b0;
      m_off          = '0;
      m_therm        = '0;
      m_trunc        = '0;
      for (int p = 0; p < PHASES; p++) begin
         m_count[p] = 0;
      end
   endtask

   // Advance the model by one clock edge on the inputs the DUT sees
   task automatic update_model();
      dmw_t              eff;
      dmw_t              cluster;
      logic [PHASES-1:0] cont_now;
      logic [LONGL-1:0]  mask;
      logic              done;
      logic              active;
      logic              over;
      logic              overlap;
      int                best;
      int                lens [PHASES];
      eff     = (m_dmw_r != 0) ? m_dmw_r : m_dmw_hold;
      done    = 1'b1;
      for (int p = 0; p < PHASES; p++) begin
         lens[p] = (m_dmw_r != 0) ? start_len(p, m_dmw_r) : m_count[p];
         if (m_limit >= lens[p] && start_len(p, eff) != 0) begin
            done = 1'b0;
         end
      end
      cluster = {m_cont_2r, m_cont_r[3:2]};
      over    = (m_dmw_r != 0) && (cluster > m_dmw_r);
      overlap = (m_dmw_r & cluster) != 0;
      active  = ((m_valid & m_cont_r) != 0) && m_cont;
      if (step_en) begin
         steps_seen++;
         for (int p = 0; p < PHASES; p++) begin
            best = 0;
            for (int t = 1; t < TILES; t++) begin
               if (tile_len[t][p] > tile_len[best][p]) begin
                  best = t;
               end
            end
            cont_now[p] = (tile_len[best][p] == LONGL);
            mask = '1;
            if (lens[p] != 0) begin
               for (int i = 0; i < mask_span(p); i++) begin
                  mask[LONGL-1-i] = (m_limit >= lens[p] - i);
               end
            end
            m_off[p]   = {2'(best), tile_offset[best][p]};
            m_therm[p] = tile_fwd_therm[best][p] & mask;
            m_trunc[p] = |(tile_fwd_therm[best][p] & ~mask);
            if (start_len(p, m_dmw_r) != 0) begin
               m_count[p] = start_len(p, m_dmw_r) + 4;
            end else if (m_count[p] != 0 && !done && active) begin
               m_count[p] = m_count[p] + 4;
            end else begin
               m_count[p] = 0;
            end
         end
         m_cont = over || overlap || (active && !m_force_done_r);
         if (m_dmw_r != 0) begin
            m_valid = over ? fold(m_dmw_r) : fold(cluster & m_dmw_r);
         end
         m_cont_2r      = m_cont_r;
         m_cont_r       = cont_now;
         m_force_done_r = done;
         m_dmw_hold     = eff;
         m_dmw_r        = dmw_start;
      end
      m_limit = decode_limit(limit_op, win_size);
   endtask

   // **************************************************************************
   // Stimulus and checks
   // **************************************************************************
   task automatic drive_inputs();
      for (int t = 0; t < TILES; t++) begin
         for (int p = 0; p < PHASES; p++) begin
            if (mode == M_MIXED && rand_bits(1) != 0) begin
               tile_len[t][p] = LONGL;
            end else begin
               tile_len[t][p] = rand_bits(4) % (LONGL + 1);
            end
            tile_fwd_therm[t][p] <= LONGL'((1 << tile_len[t][p]) - 1);
            tile_offset[t][p]    <= TILE_OFF_W'(rand_bits(TILE_OFF_W));
         end
      end
      case (mode)
         M_PLAIN: begin
            step_en   <= 1'b1;
            dmw_start <= '0;
            limit_op  <= LIMIT_WINDOW;
            win_size  <= win_size_e'(rand_bits(3));
         end
         M_HOLD: begin
            step_en   <= 1'b0;
            dmw_start <= dmw_t'(rand_bits(6));
            limit_op  <= limit_op_e'(rand_bits(2));
            win_size  <= win_size_e'(rand_bits(3));
         end
         M_LIMIT: begin
            step_en   <= 1'b1;
            dmw_start <= dmw_t'(rand_bits(6));
            limit_op  <= (rand_bits(1) != 0) ? LIMIT_64 : LIMIT_18;
         end
         M_MIXED: begin
            step_en   <= (rand_bits(2) != 0);
            dmw_start <= (rand_bits(2) == 0) ? dmw_t'(rand_bits(6)) : '0;
            limit_op  <= limit_op_e'(rand_bits(2));
            win_size  <= win_size_e'(rand_bits(3));
         end
         default: step_en <= 1'b0;
      endcase
   endtask

   task automatic compare_outputs();
      for (int p = 0; p < PHASES; p++) begin
         assert (match_offset[p] === m_off[p])
         else report_mismatch($sformatf("match_offset[%0d]", p), match_offset[p], m_off[p]);
         assert (match_fwd_therm[p] === m_therm[p])
         else report_mismatch($sformatf("match_fwd_therm[%0d]", p), match_fwd_therm[p],
                              m_therm[p]);
         assert (match_truncated[p] === m_trunc[p])
         else report_mismatch($sformatf("match_truncated[%0d]", p), match_truncated[p],
                              m_trunc[p]);
      end
      assert (match_cont === m_cont)
      else report_mismatch("match_cont", match_cont, m_cont);
   endtask

   // Drive on the rising edge and check on the falling edge
   task automatic run_cycle();
      @(posedge clk);
      update_model();
      drive_inputs();
      @(negedge clk);
      compare_outputs();
   endtask

   initial begin : watchdog
      for (int n = 0; n < MAX_CYCLES; n++) begin
         @(posedge clk);
      end
      report_failure("simulation ran past the cycle limit");
   end

   initial begin : main
      logic [PHASES-1:0][OFF_W-1:0] s_off;
      logic [PHASES-1:0][LONGL-1:0] s_therm;
      logic [PHASES-1:0]            s_trunc;
      logic                         s_cont;
      int                           seen;
      clk            = 1'b0;
      clt_rst_n      = 1'b0;
      step_en        = 1'b0;
      tile_fwd_therm = '0;
      tile_offset    = '0;
      dmw_start      = '0;
      limit_op       = LIMIT_WINDOW;
      win_size       = WIN_32K;
      lfsr           = 32'hd528_34fc;
      mode           = M_IDLE;
      steps_seen     = 0;
      for (int t = 0; t < TILES; t++) begin
         for (int p = 0; p < PHASES; p++) begin
            tile_len[t][p] = 0;
         end
      end
      reset_model();
      for (int n = 0; n < 5; n++) begin
         @(posedge clk);
      end
      clt_rst_n <= 1'b1;

      // Idle after reset
      repeat (4) begin
         run_cycle();
         assert (match_offset == '0 && match_fwd_therm == '0 && match_truncated == '0 &&
                 match_cont == 1'b0)
         else report_failure("outputs not zero after reset");
      end

      // Longest match per phase without a limit
      mode = M_PLAIN;
      repeat (200) begin
         run_cycle();
         assert (match_truncated == '0)
         else report_failure("truncation flagged with no window start");
      end

      // Outputs hold while step_en is low
      mode = M_HOLD;
      run_cycle();
      s_off   = m_off;
      s_therm = m_therm;
      s_trunc = m_trunc;
      s_cont  = m_cont;
      repeat (20) begin
         run_cycle();
         assert (match_offset == s_off && match_fwd_therm == s_therm &&
                 match_truncated == s_trunc && match_cont == s_cont)
         else report_failure("outputs changed while step_en was low");
      end

      // Masks under the short limits
      mode = M_LIMIT;
      seen = 0;
      repeat (300) begin
         run_cycle();
         seen += (match_truncated != '0);
      end
      assert (seen > 0)
      else report_failure("no truncation seen under the short limits");

      // Mixed steps with mostly full thermometers
      mode       = M_MIXED;
      steps_seen = 0;
      seen       = 0;
      for (int c = 0; c < 4000 && steps_seen < 2000; c++) begin
         run_cycle();
         seen += match_cont;
      end
      assert (steps_seen >= 2000)
      else report_failure("mixed sequence did not reach its step count in time");
      assert (seen > 0)
      else report_failure("match_cont never rose in the mixed sequence");

      $display("Regression passed");
      $finish;
   end

endmodule

// ==== logic/lz77_cluster.sv ====
// LZ77 match cluster top level
// Per-phase selection trees, length tracker and output stage

`timescale 1ns/10ps

module lz77_cluster #(
   parameter  int TILES      = 4,
   parameter  int LONGL      = 12,
   parameter  int TILE_OFF_W = 3,
   localparam int OFF_W      = $clog2(TILES) + TILE_OFF_W
) (
   input  logic                                                      clk,
   input  logic                                                      clt_rst_n,
   input  logic                                                      step_en,
   input  logic [TILES-1:0][lz77_clt_pkg::PHASES-1:0][LONGL-1:0]      tile_fwd_therm,
   input  logic [TILES-1:0][lz77_clt_pkg::PHASES-1:0][TILE_OFF_W-1:0] tile_offset,
   input  lz77_clt_pkg::dmw_t                                        dmw_start,
   input  lz77_clt_pkg::limit_op_e                                   limit_op,
   input  lz77_clt_pkg::win_size_e                                   win_size,
   output logic [lz77_clt_pkg::PHASES-1:0][OFF_W-1:0]                 match_offset,
   output logic [lz77_clt_pkg::PHASES-1:0][LONGL-1:0]                 match_fwd_therm,
   output logic [lz77_clt_pkg::PHASES-1:0]                            match_truncated,
   output logic                                                      match_cont
);
   import lz77_clt_pkg::*;

   logic [PHASES-1:0][LONGL-1:0] sel_therm;
   logic [PHASES-1:0][OFF_W-1:0] sel_offset;

   clt_phase_if #(.LONGL(LONGL)) phase_bus ();

   // One tree per phase, tile reports regrouped by phase
   for (genvar p = 0; p < PHASES; p++) begin : g_phase
      logic [TILES-1:0][LONGL-1:0]      therm_col;
      logic [TILES-1:0][TILE_OFF_W-1:0] off_col;

      for (genvar t = 0; t < TILES; t++) begin : g_tile
         assign therm_col[t] = tile_fwd_therm[t][p];
         assign off_col[t]   = tile_offset[t][p];
      end

      match_select_tree #(
         .TILES      (TILES),
         .LONGL      (LONGL),
         .TILE_OFF_W (TILE_OFF_W)
      ) i_select_tree (
         .tile_therm  (therm_col),
         .tile_off    (off_col),
         .best_therm  (sel_therm[p]),
         .best_offset (sel_offset[p])
      );
   end

   phase_length_tracker #(
      .LONGL (LONGL)
   ) i_tracker (
      .clk       (clk),
      .clt_rst_n (clt_rst_n),
      .step_en   (step_en),
      .dmw_start (dmw_start),
      .limit_op  (limit_op),
      .win_size  (win_size),
      .phase_bus (phase_bus.tracker)
   );

   match_output_stage #(
      .TILES      (TILES),
      .LONGL      (LONGL),
      .TILE_OFF_W (TILE_OFF_W)
   ) i_output_stage (
      .clk             (clk),
      .clt_rst_n       (clt_rst_n),
      .step_en         (step_en),
      .phase_therm     (sel_therm),
      .phase_offset    (sel_offset),
      .phase_bus       (phase_bus.out_stage),
      .match_offset    (match_offset),
      .match_fwd_therm (match_fwd_therm),
      .match_truncated (match_truncated),
      .match_cont      (match_cont)
   );

endmodule

// ==== logic/match_output_stage.sv ====
// Registered match outputs of the cluster
// Truncation by phase mask, continue flag and valid-phase tracking

`timescale 1ns/10ps

module match_output_stage #(
   parameter  int TILES      = 4,
   parameter  int LONGL      = 12,
   parameter  int TILE_OFF_W = 3,
   localparam int OFF_W      = $clog2(TILES) + TILE_OFF_W
) (
   input  logic                                     clk,
   input  logic                                     clt_rst_n,
   input  logic                                     step_en,
   input  logic [lz77_clt_pkg::PHASES-1:0][LONGL-1:0] phase_therm,
   input  logic [lz77_clt_pkg::PHASES-1:0][OFF_W-1:0] phase_offset,
   clt_phase_if.out_stage                           phase_bus,
   output logic [lz77_clt_pkg::PHASES-1:0][OFF_W-1:0] match_offset,
   output logic [lz77_clt_pkg::PHASES-1:0][LONGL-1:0] match_fwd_therm,
   output logic [lz77_clt_pkg::PHASES-1:0]            match_truncated,
   output logic                                     match_cont
);
   import lz77_clt_pkg::*;

   logic [PHASES-1:0] cont_now;
   logic [PHASES-1:0] valid_phases;
   logic              force_done_r;
   logic              dmw_any;
   logic              cont_over;
   logic              cont_overlap;

   // Fold a 6-bit window vector onto the four phases
   function automatic logic [PHASES-1:0] fold_phases(input dmw_t v);
      fold_phases = v[DMW_BITS-1 -: PHASES] | {v[1:0], 2'b00};
   endfunction

   // A phase continues when its best thermometer is full
   always_comb begin
      for (int p = 0; p < PHASES; p++) begin
         cont_now[p] = phase_therm[p][LONGL-1];
      end
   end

   assign phase_bus.cluster_cont_phases = {phase_bus.cont_phases_2r,
                                           phase_bus.cont_phases_r[PHASES-1 -: 2]};

   assign dmw_any      = |phase_bus.dmw_r;
   assign cont_over    = dmw_any && (phase_bus.cluster_cont_phases > phase_bus.dmw_r);
   assign cont_overlap = dmw_any && (|(phase_bus.cluster_cont_phases & phase_bus.dmw_r));

   // Ongoing phases are the registered MSBs
   assign phase_bus.cont_active = (|(valid_phases & phase_bus.cont_phases_r)) && match_cont;

   // **************************************************************************
   // Step registers
   // **************************************************************************
   always_ff @(posedge clk or negedge clt_rst_n) begin
      if (!clt_rst_n) begin
         match_offset             <= '0;
         match_fwd_therm          <= '0;
         match_truncated          <= '0;
         match_cont               <= 1'b0;
         phase_bus.cont_phases_r  <= '0;
         phase_bus.cont_phases_2r <= '0;
         valid_phases             <= '0;
         force_done_r             <= 1'b0;
      end else if (step_en) begin
         phase_bus.cont_phases_r  <= cont_now;
         phase_bus.cont_phases_2r <= phase_bus.cont_phases_r;
         force_done_r             <= phase_bus.force_done;

         match_cont <= cont_over || cont_overlap ||
                       (phase_bus.cont_active && !force_done_r);

         if (dmw_any) begin
            if (cont_over) begin
               valid_phases <= fold_phases(phase_bus.dmw_r);
            end else begin
               valid_phases <= fold_phases(phase_bus.cluster_cont_phases & phase_bus.dmw_r);
            end
         end

         match_offset <= phase_offset;
         for (int p = 0; p < PHASES; p++) begin
            match_fwd_therm[p] <= phase_therm[p] & phase_bus.phase_mask[p];
            match_truncated[p] <= |(phase_therm[p] & ~phase_bus.phase_mask[p]);
         end
      end
   end

endmodule

// ==== logic/phase_length_tracker.sv ====
// Match length limit decode and per-phase continuation lengths
// Builds the truncation masks and the force-done flag

`timescale 1ns/10ps

module phase_length_tracker #(
   parameter int LONGL = 12
) (
   input  logic                    clk,
   input  logic                    clt_rst_n,
   input  logic                    step_en,
   input  lz77_clt_pkg::dmw_t      dmw_start,
   input  lz77_clt_pkg::limit_op_e limit_op,
   input  lz77_clt_pkg::win_size_e win_size,
   clt_phase_if.tracker            phase_bus
);
   import lz77_clt_pkg::*;

   len_t              limit;
   dmw_t              dmw_hold;
   dmw_t              dmw_eff;
   logic [PHASES-1:0] phase_done;

   // **************************************************************************
   // Limit register, follows the config every cycle
   // **************************************************************************
   always_ff @(posedge clk or negedge clt_rst_n) begin
      if (!clt_rst_n) begin
         limit <= '0;
      end else begin
         case (limit_op)
            LIMIT_258: limit <= len_t'(258);
            LIMIT_18:  limit <= len_t'(18);
            LIMIT_64:  limit <= len_t'(64);
            default: begin
               case (win_size)
                  WIN_512: limit <= len_t'(512);
                  WIN_4K:  limit <= len_t'(4096);
                  WIN_8K:  limit <= len_t'(8192);
                  WIN_16K: limit <= len_t'(16384);
                  WIN_32K: limit <= len_t'(32768);
                  default: limit <= len_t'(65535);
               endcase
            end
         endcase
      end
   end

   // Window start vector and the last nonzero one
   always_ff @(posedge clk or negedge clt_rst_n) begin
      if (!clt_rst_n) begin
         phase_bus.dmw_r <= '0;
         dmw_hold        <= '0;
      end else if (step_en) begin
         phase_bus.dmw_r <= dmw_start;
         dmw_hold        <= dmw_eff;
      end
   end

   assign dmw_eff = (|phase_bus.dmw_r) ? phase_bus.dmw_r : dmw_hold;

   // **************************************************************************
   // Per-phase length, counter and mask
   // **************************************************************************
   for (genvar p = 0; p < PHASES; p++) begin : g_phase
      // Phases 1 and 2 own a single dmw bit
      localparam int HI = p + 2;
      localparam int LO = (p >= 2) ? p - 2 : p + 2;

      logic             load;
      len_t             start_len;
      len_t             count;
      len_t             len;
      logic [LONGL-1:0] mask;

      assign load      = phase_bus.dmw_r[HI] | phase_bus.dmw_r[LO];
      assign start_len = phase_bus.dmw_r[HI] ? DMW_START_LEN[HI] :
                         phase_bus.dmw_r[LO] ? DMW_START_LEN[LO] : '0;
      assign len       = (|phase_bus.dmw_r) ? start_len : count;

      always_ff @(posedge clk or negedge clt_rst_n) begin
         if (!clt_rst_n) begin
            count <= '0;
         end else if (step_en) begin
            if (load) begin
               count <= start_len + len_t'(PHASE_STEP);
            end else if ((|count) && !phase_bus.force_done && phase_bus.cont_active) begin
               count <= count + len_t'(PHASE_STEP);
            end else begin
               count <= '0;
            end
         end
      end

      // Trim the top bits that would run past the limit
      always_comb begin
         mask = '1;
         if (|len) begin
            for (int i = 0; i < MASK_SPAN[p]; i++) begin
               mask[LONGL-1-i] = (limit >= len - i);
            end
         end
      end

      assign phase_bus.phase_mask[p] = mask;
      assign phase_done[p] = (limit < len) || !(dmw_eff[HI] | dmw_eff[LO]);
   end

   assign phase_bus.force_done = &phase_done;

endmodule

// ==== logic/match_select_tree.sv ====
// Longest-match selection for one phase across all tiles
// Binary reduction tree, lower tile index wins a tie

`timescale 1ns/10ps

module match_select_tree #(
   parameter  int TILES      = 4,
   parameter  int LONGL      = 12,
   parameter  int TILE_OFF_W = 3,
   localparam int OFF_W      = $clog2(TILES) + TILE_OFF_W
) (
   input  logic [TILES-1:0][LONGL-1:0]      tile_therm,
   input  logic [TILES-1:0][TILE_OFF_W-1:0] tile_off,
   output logic [LONGL-1:0]                 best_therm,
   output logic [OFF_W-1:0]                 best_offset
);

   localparam int IDX_W  = $clog2(TILES);
   localparam int LEAVES = 1 << IDX_W;
   localparam int NODES  = 2 * LEAVES - 1;

   // Heap order: node k has children 2k+1 and 2k+2, leaves at the end
   logic [NODES-1:0][LONGL-1:0] node_therm;
   logic [NODES-1:0][OFF_W-1:0] node_off;

   // **************************************************************************
   // Leaves
   // **************************************************************************
   for (genvar t = 0; t < LEAVES; t++) begin : g_leaf
      if (t < TILES) begin : g_tile
         assign node_therm[LEAVES-1+t] = tile_therm[t];
         assign node_off[LEAVES-1+t]   = {IDX_W'(t), tile_off[t]};
      end else begin : g_pad
         // Empty slot never wins, the real tile to its left takes ties
         assign node_therm[LEAVES-1+t] = '0;
         assign node_off[LEAVES-1+t]   = '0;
      end
   end

   // **************************************************************************
   // Compare nodes
   // **************************************************************************
   for (genvar k = 0; k < LEAVES - 1; k++) begin : g_node
      logic keep_left;

      // Thermometer codes order the same way as their lengths
      assign keep_left = node_therm[2*k+1] >= node_therm[2*k+2];

      assign node_therm[k] = keep_left ? node_therm[2*k+1] : node_therm[2*k+2];
      assign node_off[k]   = keep_left ? node_off[2*k+1]   : node_off[2*k+2];
   end

   assign best_therm  = node_therm[0];
   assign best_offset = node_off[0];

endmodule

// ==== logic/clt_phase_if.sv ====
// Phase bus between the length tracker and the output stage
// Masks and window state one way, continuation state the other

`timescale 1ns/10ps

interface clt_phase_if #(
   parameter int LONGL = 12
);
   import lz77_clt_pkg::*;

   // Tracker side
   logic [PHASES-1:0][LONGL-1:0] phase_mask;
   logic                         force_done;
   dmw_t                         dmw_r;

   // Output stage side
   logic                         cont_active;
   logic [PHASES-1:0]            cont_phases_r;
   logic [PHASES-1:0]            cont_phases_2r;
   dmw_t                         cluster_cont_phases;

   modport tracker (
      output phase_mask, force_done, dmw_r,
      input  cont_active
   );

   modport out_stage (
      input  phase_mask, force_done, dmw_r,
      output cont_active, cont_phases_r, cont_phases_2r, cluster_cont_phases
   );

endinterface

// ==== logic/lz77_clt_pkg.sv ====
// Types and constants shared by the LZ77 match cluster
// Phase and window sizes, start lengths, mask spans, limit and window codes

package lz77_clt_pkg;

   // Byte phases resolved per cycle
   localparam int PHASES     = 4;
   localparam int DMW_BITS   = 6;
   localparam int LEN_WIDTH  = 17;
   localparam int PHASE_STEP = 4;

   typedef logic [LEN_WIDTH-1:0] len_t;
   typedef logic [DMW_BITS-1:0]  dmw_t;

   // Start length per dmw bit, bit 0 first
   // Bits 5..2 start phases 4..1, bit 1 starts phase 4, bit 0 starts phase 3
   localparam len_t DMW_START_LEN [DMW_BITS] = '{
      len_t'(19),
      len_t'(20),
      len_t'(21),
      len_t'(22),
      len_t'(23),
      len_t'(24)
   };

   // Top thermometer bits each phase may trim, phase 1 first
   localparam int MASK_SPAN [PHASES] = '{8, 8, 9, 10};

   // Max match length select
   typedef enum logic [1:0] {
      LIMIT_WINDOW = 2'd0,
      LIMIT_258    = 2'd1,
      LIMIT_18     = 2'd2,
      LIMIT_64     = 2'd3
   } limit_op_e;

   // Window size, codes above 4 give the 64K limit
   typedef enum logic [2:0] {
      WIN_512 = 3'd0,
      WIN_4K  = 3'd1,
      WIN_8K  = 3'd2,
      WIN_16K = 3'd3,
      WIN_32K = 3'd4,
      WIN_64K = 3'd5
   } win_size_e;

endpackage
